// ==== sources.f ====
+incdir+hdl
hdl/enable_gen_pkg.sv
hdl/axil_register_bank.sv
hdl/timebase_counter.sv
hdl/enable_comparator.sv
hdl/enable_generator.sv
tb/enable_generator_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = enable_generator_tb
FILELIST = sources.f

OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/enable_generator_tb.sv ====
/*
 * Enable generator testbench
 * Random AXI-lite traffic and enable stimulus checked against a cycle model
 */
`timescale 1ns/1ps
`include "enable_gen_consts.svh"

module enable_generator_tb;
    import enable_gen_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int W = `EG_COUNTER_WIDTH;

    logic clock, rst_n;
    reg_word_t awaddr, wdata, araddr, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    axil_resp_t bresp, rresp;
    logic ext_timebase, gen_enable_in, enable_out_1, enable_out_2;

    // Model state that mirrors the registers, the count and the pulse registers
    logic [1:0] m_ctrl;
    count_t m_period, m_threshold_1, m_threshold_2, m_count;
    logic m_advance, m_out_1, m_out_2, m_enable, m_tick;
    logic [2:0] tb_history;
    logic monitor_on;

    enable_generator dut (.*);

    always #50 clock = ~clock;

    function automatic logic is_mapped(input reg_word_t addr);
        return (addr[31:4] == 28'h0) && (addr[1:0] == 2'b00);
    endfunction

    function automatic reg_word_t model_read(input reg_word_t addr);
        if (!is_mapped(addr))
            return '0;
        case (addr[3:0])
            `EG_REG_CTRL:   return {30'h0, m_ctrl};
            `EG_REG_PERIOD: return {{(32 - W){1'b0}}, m_period};
            `EG_REG_THR1:   return {{(32 - W){1'b0}}, m_threshold_1};
            default:        return {{(32 - W){1'b0}}, m_threshold_2};
        endcase
    endfunction

    // Two flops of synchronizer and one of edge detect put the tick on the third edge
    assign m_enable = m_ctrl[`EG_CTRL_ENABLE] | gen_enable_in;
    assign m_tick = m_ctrl[`EG_CTRL_EXT_TB] ? (tb_history[1] & ~tb_history[2]) : 1'b1;

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_ctrl <= '0;
            m_period <= '0;
            m_threshold_1 <= '0;
            m_threshold_2 <= '0;
            m_count <= '0;
            m_advance <= 1'b0;
            m_out_1 <= 1'b0;
            m_out_2 <= 1'b0;
            tb_history <= '0;
        end else begin
            tb_history <= {tb_history[1:0], ext_timebase};
            if (awvalid && wvalid && awready && is_mapped(awaddr)) begin
                case (awaddr[3:0])
                    `EG_REG_CTRL:   m_ctrl <= {wdata[`EG_CTRL_EXT_TB], wdata[`EG_CTRL_ENABLE]};
                    `EG_REG_PERIOD: m_period <= wdata[W-1:0];
                    `EG_REG_THR1:   m_threshold_1 <= wdata[W-1:0];
                    default:        m_threshold_2 <= wdata[W-1:0];
                endcase
            end
            if (!m_enable) begin
                m_count <= '0;
                m_advance <= 1'b0;
            end else begin
                m_advance <= m_tick;
                if (m_tick)
                    m_count <= (m_count == m_period) ? count_t'(0) : count_t'(m_count + 1);
            end
            m_out_1 <= m_advance && (m_count == m_threshold_1);
            m_out_2 <= m_advance && (m_count == m_threshold_2);
        end
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check(input string name, input reg_word_t observed, input reg_word_t expected);
        if (observed !== expected) begin
            fail_now($sformatf("Error: %s is 0x%h, expected 0x%h", name, observed, expected));
        end
    endtask

    // Outputs are flops, so the falling edge sees them settled
    always @(negedge clock) begin
        if (monitor_on) begin
            check("enable_out_1", enable_out_1, m_out_1);
            check("enable_out_2", enable_out_2, m_out_2);
        end
    end

    // During a hold the same write stays offered and must not be taken
    task automatic axil_write(input reg_word_t addr, input reg_word_t data, input int hold,
                              output axil_resp_t resp);
        int waited;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        waited = 0;
        while (!(awready && wready)) begin
            @(negedge clock);
            if (++waited > TIMEOUT)
                fail_now("Timeout: the write address and data were never accepted");
        end
        @(negedge clock);
        awvalid = (hold > 0);
        wvalid = (hold > 0);
        waited = 0;
        while (!bvalid) begin
            @(negedge clock);
            if (++waited > TIMEOUT)
                fail_now("Timeout: no write response came back");
        end
        resp = bresp;
        repeat (hold) begin
            @(negedge clock);
            check("awready", awready, 0);
            check("wready", wready, 0);
            check("bvalid", bvalid, 1);
            check("bresp", bresp, resp);
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic axil_read(input reg_word_t addr, input int hold, output reg_word_t data,
                             output axil_resp_t resp);
        int waited;
        araddr = addr;
        arvalid = 1'b1;
        waited = 0;
        while (!arready) begin
            @(negedge clock);
            if (++waited > TIMEOUT)
                fail_now("Timeout: the read address was never accepted");
        end
        @(negedge clock);
        arvalid = (hold > 0);
        waited = 0;
        while (!rvalid) begin
            @(negedge clock);
            if (++waited > TIMEOUT)
                fail_now("Timeout: no read data came back");
        end
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clock);
            check("arready", arready, 0);
            check("rvalid", rvalid, 1);
            check("rdata", rdata, data);
            check("rresp", rresp, resp);
        end
        arvalid = 1'b0;
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
    endtask

    task automatic write_expect(input reg_word_t addr, input reg_word_t data, input int hold);
        axil_resp_t resp;
        axil_write(addr, data, hold, resp);
        check("bresp", resp, is_mapped(addr) ? RESP_OKAY : RESP_SLVERR);
    endtask

    task automatic read_expect(input reg_word_t addr, input int hold);
        reg_word_t data;
        axil_resp_t resp;
        axil_read(addr, hold, data, resp);
        check("rresp", resp, is_mapped(addr) ? RESP_OKAY : RESP_SLVERR);
        check("rdata", data, model_read(addr));
    endtask

    task automatic read_all();
        read_expect(`EG_REG_CTRL, 0);
        read_expect(`EG_REG_PERIOD, 0);
        read_expect(`EG_REG_THR1, 0);
        read_expect(`EG_REG_THR2, 0);
    endtask

    initial begin
        int offset;
        int period_val;
        int gap;
        clock = 1'b0;
        rst_n = 1'b0;
        {awaddr, wdata, araddr} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        ext_timebase = 1'b0;
        gen_enable_in = 1'b0;
        monitor_on = 1'b0;
        void'($urandom(32'hd58b));
        repeat (10) @(posedge clock);
        monitor_on = 1'b1;
        @(negedge clock);
        rst_n = 1'b1;

        // After reset every register reads back as 0
        check("awready", awready, 0);
        check("wready", wready, 0);
        check("bvalid", bvalid, 0);
        check("arready", arready, 0);
        check("rvalid", rvalid, 0);
        read_all();

        // Random register access followed by unmapped offsets inside the window
        repeat (24) begin
            offset = $urandom_range(0, 3) * 4;
            write_expect(offset, $urandom, 0);
            read_expect(offset, 0);
        end
        repeat (6) begin
            offset = $urandom_range(0, 3) * 4 + $urandom_range(1, 3);
            write_expect(offset, $urandom, 0);
            read_expect(offset, 0);
            read_all();
        end

        // Internal timebase where thresholds above the period never fire
        repeat (3) begin
            period_val = $urandom_range(0, 30);
            write_expect(`EG_REG_CTRL, 0, 0);
            write_expect(`EG_REG_PERIOD, period_val, 0);
            write_expect(`EG_REG_THR1, $urandom_range(0, period_val), 0);
            write_expect(`EG_REG_THR2, $urandom_range(0, period_val + 8), 0);
            write_expect(`EG_REG_CTRL, 32'h1 << `EG_CTRL_ENABLE, 0);
            repeat (300) @(negedge clock);
        end

        // The enable pin alone starts and stops the generator
        write_expect(`EG_REG_CTRL, 0, 0);
        write_expect(`EG_REG_PERIOD, $urandom_range(3, 20), 0);
        write_expect(`EG_REG_THR1, $urandom_range(0, 3), 0);
        repeat (500) begin
            @(negedge clock);
            if ($urandom_range(0, 39) == 0)
                gen_enable_in = !gen_enable_in;
        end
        gen_enable_in = 1'b0;

        // External timebase with edges at least four cycles apart
        write_expect(`EG_REG_PERIOD, $urandom_range(2, 6), 0);
        write_expect(`EG_REG_THR2, $urandom_range(0, 2), 0);
        write_expect(`EG_REG_CTRL, (32'h1 << `EG_CTRL_ENABLE) | (32'h1 << `EG_CTRL_EXT_TB), 0);
        gap = 4;
        repeat (800) begin
            @(negedge clock);
            gap--;
            if (gap == 0) begin
                ext_timebase = !ext_timebase;
                gap = $urandom_range(4, 10);
            end
        end

        // Back-pressure on both response channels
        repeat (12) begin
            offset = $urandom_range(0, 3) * 4;
            write_expect(offset, $urandom, $urandom_range(1, 8));
            read_expect(offset, $urandom_range(1, 8));
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== hdl/enable_generator.sv ====
/*
 * Enable generator top level
 * Register bank, timebase counter and two enable comparators
 */
`timescale 1ns/1ps

module enable_generator #(
    parameter enable_gen_pkg::reg_word_t BASE_ADDRESS = '0
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  enable_gen_pkg::reg_word_t  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  enable_gen_pkg::reg_word_t  wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output enable_gen_pkg::axil_resp_t bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  enable_gen_pkg::reg_word_t  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output enable_gen_pkg::reg_word_t  rdata,
    output enable_gen_pkg::axil_resp_t rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic                       ext_timebase,
    input  logic                       gen_enable_in,
    output logic                       enable_out_1,
    output logic                       enable_out_2
);
    import enable_gen_pkg::*;

    logic   enable_bit;
    logic   ext_tb_select;
    logic   gen_enable;
    logic   advance;
    count_t period;
    count_t threshold_1;
    count_t threshold_2;
    count_t count;

    // Either the control register or the pin can run the generator
    assign gen_enable = enable_bit | gen_enable_in;

    axil_register_bank #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) regs (
        .clock(clock),
        .rst_n(rst_n),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .enable_bit(enable_bit),
        .ext_tb_select(ext_tb_select),
        .period(period),
        .threshold_1(threshold_1),
        .threshold_2(threshold_2)
    );

    timebase_counter counter (
        .clock(clock),
        .rst_n(rst_n),
        .ext_timebase(ext_timebase),
        .ext_tb_select(ext_tb_select),
        .gen_enable(gen_enable),
        .period(period),
        .count(count),
        .advance(advance)
    );

    enable_comparator comparator_1 (
        .clock(clock),
        .rst_n(rst_n),
        .advance(advance),
        .count(count),
        .threshold(threshold_1),
        .enable_out(enable_out_1)
    );

    enable_comparator comparator_2 (
        .clock(clock),
        .rst_n(rst_n),
        .advance(advance),
        .count(count),
        .threshold(threshold_2),
        .enable_out(enable_out_2)
    );

endmodule

// ==== hdl/enable_comparator.sv ====
/*
 * Enable comparator
 * One-cycle enable pulse when a freshly advanced count matches the threshold
 */
`timescale 1ns/1ps

module enable_comparator (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   advance,
    input  enable_gen_pkg::count_t count,
    input  enable_gen_pkg::count_t threshold,
    output logic                   enable_out
);
    import enable_gen_pkg::*;

    logic hit;

    // Gating with advance keeps a slow external timebase from holding the output high
    assign hit = advance && (count == threshold);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            enable_out <= 1'b0;
        end else begin
            enable_out <= hit;
        end
    end

    // Back-to-back pulses need the count to sit at 0 on every edge,
    // which only a zero period does
    single_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        enable_out && $past(enable_out) && $past(threshold, 2) == $past(threshold)
        |-> $past(count) == count_t'(0));

endmodule

// ==== hdl/timebase_counter.sv ====
/*
 * Timebase counter
 * Wrapping period counter driven by the clock or a synchronized external timebase
 */
`timescale 1ns/1ps

module timebase_counter (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   ext_timebase,
    input  logic                   ext_tb_select,
    input  logic                   gen_enable,
    input  enable_gen_pkg::count_t period,
    output enable_gen_pkg::count_t count,
    output logic                   advance
);
    import enable_gen_pkg::*;

    logic   sync_0;
    logic   sync_1;
    logic   sync_2;
    logic   tick;
    count_t next_count;

    // Two flops for metastability, the third one only finds the rising edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
        end else begin
            sync_0 <= ext_timebase;
            sync_1 <= sync_0;
            sync_2 <= sync_1;
        end
    end

    assign tick = ext_tb_select ? (sync_1 && !sync_2) : 1'b1;
    assign next_count = (count == period) ? '0 : count + 1'b1;

    // Advance marks the cycle right after the count was stepped by a tick
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            advance <= 1'b0;
        end else if (!gen_enable) begin
            count <= '0;
            advance <= 1'b0;
        end else begin
            advance <= tick;
            if (tick) begin
                count <= next_count;
            end
        end
    end

    count_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        gen_enable && $stable(period) && $past(count) <= $past(period) |-> count <= period);

endmodule

// ==== hdl/axil_register_bank.sv ====
/*
 * AXI-lite register bank
 * Holds the control, period and threshold registers of the enable generator
 */
`timescale 1ns/1ps
`include "enable_gen_consts.svh"

module axil_register_bank #(
    parameter enable_gen_pkg::reg_word_t BASE_ADDRESS = '0
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  enable_gen_pkg::reg_word_t  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  enable_gen_pkg::reg_word_t  wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output enable_gen_pkg::axil_resp_t bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  enable_gen_pkg::reg_word_t  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output enable_gen_pkg::reg_word_t  rdata,
    output enable_gen_pkg::axil_resp_t rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       enable_bit,
    output logic                       ext_tb_select,
    output enable_gen_pkg::count_t     period,
    output enable_gen_pkg::count_t     threshold_1,
    output enable_gen_pkg::count_t     threshold_2
);
    import enable_gen_pkg::*;

    localparam int PAD_BITS = 32 - `EG_COUNTER_WIDTH;

    logic      write_ready;
    logic      write_fire;
    logic      write_hit;
    logic      read_fire;
    logic      read_hit;
    reg_word_t ctrl_word;
    reg_word_t read_word;

    assign awready = write_ready;
    assign wready = write_ready;

    // Address and data are taken together, so one ready serves both channels
    assign write_fire = write_ready && awvalid && wvalid;
    assign read_fire = arready && arvalid;

    assign write_hit = (awaddr[31:4] == BASE_ADDRESS[31:4]) && (awaddr[1:0] == 2'b00);
    assign read_hit = (araddr[31:4] == BASE_ADDRESS[31:4]) && (araddr[1:0] == 2'b00);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[`EG_CTRL_ENABLE] = enable_bit;
        ctrl_word[`EG_CTRL_EXT_TB] = ext_tb_select;
    end

    // Word offsets 0, 4, 8 and C cover the whole window, alignment is the only miss
    always_comb begin
        case (araddr[3:0])
            `EG_REG_CTRL:   read_word = ctrl_word;
            `EG_REG_PERIOD: read_word = {{PAD_BITS{1'b0}}, period};
            `EG_REG_THR1:   read_word = {{PAD_BITS{1'b0}}, threshold_1};
            `EG_REG_THR2:   read_word = {{PAD_BITS{1'b0}}, threshold_2};
            default:        read_word = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_ready <= 1'b0;
            bvalid <= 1'b0;
            enable_bit <= 1'b0;
            ext_tb_select <= 1'b0;
            period <= '0;
            threshold_1 <= '0;
            threshold_2 <= '0;
        end else begin
            // A new write is only offered once the previous response has gone
            write_ready <= awvalid && wvalid && !write_ready && !bvalid;
            if (write_fire) begin
                bvalid <= 1'b1;
                if (write_hit) begin
                    case (awaddr[3:0])
                        `EG_REG_CTRL: begin
                            enable_bit <= wdata[`EG_CTRL_ENABLE];
                            ext_tb_select <= wdata[`EG_CTRL_EXT_TB];
                        end
                        `EG_REG_PERIOD: period <= wdata[`EG_COUNTER_WIDTH-1:0];
                        `EG_REG_THR1:   threshold_1 <= wdata[`EG_COUNTER_WIDTH-1:0];
                        `EG_REG_THR2:   threshold_2 <= wdata[`EG_COUNTER_WIDTH-1:0];
                        default:        ;
                    endcase
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_fire) begin
            bresp <= write_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (read_fire) begin
            rdata <= read_hit ? read_word : '0;
            rresp <= read_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Responses stay put while the master holds off
    bvalid_held: assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    rvalid_held: assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== hdl/enable_gen_pkg.sv ====
/*
 * Enable generator package
 * Count and bus word types, AXI-lite response codes
 */
`include "enable_gen_consts.svh"

package enable_gen_pkg;

    // Timebase count, period and threshold values
    typedef logic [`EG_COUNTER_WIDTH-1:0] count_t;

    // One AXI-lite data or address word
    typedef logic [31:0] reg_word_t;

    // Only the two responses the register bank can give
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

endpackage

// ==== hdl/enable_gen_consts.svh ====
/*
 * Enable generator constants
 * Counter width, register offsets and control bit positions
 */
`ifndef ENABLE_GEN_CONSTS_SVH
`define ENABLE_GEN_CONSTS_SVH

// Width shared by the count, the period and both thresholds
`define EG_COUNTER_WIDTH 16

// Byte offsets inside the 16-byte register window
`define EG_REG_CTRL   4'h0
`define EG_REG_PERIOD 4'h4
`define EG_REG_THR1   4'h8
`define EG_REG_THR2   4'hC

// Control word bits
`define EG_CTRL_ENABLE 0
`define EG_CTRL_EXT_TB 1

`endif
